//--- design/ntt_pkg.sv
package ntt_pkg;

    // coefficient width and modulus for Kyber arithmetic
    localparam int COEF_W = 12;
    localparam logic [COEF_W-1:0] NTT_Q = 12'd3329;

    // transform size, eight points over three radix-2 stages
    localparam int NTT_N          = 8;
    localparam int ADDR_W         = 3;
    localparam int NTT_STAGES     = 3;
    localparam int BFLY_PER_STAGE = 4;

    // barrett reduction of a 24 bit product, m = floor(2^24 / q)
    localparam logic [COEF_W:0] BARRETT_M     = 13'd5039;
    localparam int              BARRETT_SHIFT = 2 * COEF_W;

    // wishbone data width and word address map
    // word addresses 0 to 7 are the coefficient slots
    localparam int BUS_DW   = 32;
    localparam int REG_CTRL = 8;

    // powers of the primitive 8th root w = 17^32 mod q = 2580
    // entry k holds w^k, the sequencer indexes it in bit-reversed group order
    localparam logic [3:0][COEF_W-1:0] TWIDDLE_TABLE = {
        12'd3289,
        12'd1729,
        12'd2580,
        12'd1
    };

    typedef enum logic [1:0] {
        NTT_IDLE,
        NTT_ISSUE,
        NTT_DRAIN,
        NTT_DONE
    } ntt_state_e;

    // bit positions in the control/status register
    typedef enum int {
        CTRL_START = 0,
        STAT_DONE  = 1
    } ctrl_bit_e;

    // busy is reported on the same bit that start is written to
    localparam ctrl_bit_e STAT_BUSY = CTRL_START;

endpackage

//--- design/ntt_wb_slave.sv
`timescale 1ns/1ps

module ntt_wb_slave import ntt_pkg::*; (
    input  logic              ntt_clk_i,
    input  logic              ntt_rst_ni,
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  logic [3:0]        i_wb_adr,
    input  logic [BUS_DW-1:0] i_wb_dat,
    input  logic [COEF_W-1:0] i_bus_rdata,
    input  logic              i_busy,
    input  logic              i_done_pulse,
    output logic [BUS_DW-1:0] o_wb_dat,
    output logic              o_wb_ack,
    output logic              o_wb_err,
    output logic              o_ntt_intr,
    output logic [ADDR_W-1:0] o_bus_addr,
    output logic              o_bus_we,
    output logic [COEF_W-1:0] o_bus_wdata,
    output logic              o_start
);

    logic req;
    logic is_ctrl;
    logic bad_addr;
    logic is_coef;
    logic reject;
    logic sel_ctrl_q;
    logic done_q;

    // a cycle is taken once, the host still holds stb while it sees the response
    assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~o_wb_err;

    assign is_ctrl  = (i_wb_adr == 4'(REG_CTRL));
    assign bad_addr = (i_wb_adr > 4'(REG_CTRL));
    assign is_coef  = ~is_ctrl & ~bad_addr;

    // the engine owns the memory while busy, so coefficient slots are refused
    assign reject = bad_addr | (is_coef & i_busy);

    // the ram sees the address on every cycle and returns read data one clock later
    assign o_bus_addr  = i_wb_adr[ADDR_W-1:0];
    assign o_bus_we    = req & i_wb_we & is_coef & ~i_busy;
    assign o_bus_wdata = i_wb_dat[COEF_W-1:0];

    // a start while busy is dropped but the write is still acknowledged
    assign o_start = req & i_wb_we & is_ctrl & i_wb_dat[CTRL_START] & ~i_busy;

    always_ff @(posedge ntt_clk_i or posedge ntt_rst_ni) begin
        if (ntt_rst_ni) begin
            o_wb_ack   <= 1'b0;
            o_wb_err   <= 1'b0;
            sel_ctrl_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            o_wb_ack   <= req & ~reject;
            o_wb_err   <= req & reject;
            sel_ctrl_q <= is_ctrl;
            // a new start clears the previous result flag
            if (o_start) begin
                done_q <= 1'b0;
            end else if (i_done_pulse) begin
                done_q <= 1'b1;
            end
        end
    end

    // read data mux, status word or the coefficient from the ram port
    always_comb begin
        o_wb_dat = '0;
        if (sel_ctrl_q) begin
            o_wb_dat[STAT_BUSY] = i_busy;
            o_wb_dat[STAT_DONE] = done_q;
        end else begin
            o_wb_dat[COEF_W-1:0] = i_bus_rdata;
        end
    end

    // the interrupt line follows the done flag
    assign o_ntt_intr = done_q;

    // a cycle ends with ack or err, never both
    a_ack_err_excl : assert property (@(posedge ntt_clk_i) disable iff (ntt_rst_ni)
        !(o_wb_ack && o_wb_err));

endmodule

//--- design/ntt_coef_ram.sv
`timescale 1ns/1ps

module ntt_coef_ram import ntt_pkg::*; (
    input  logic              ntt_clk_i,
    input  logic              ntt_rst_ni,
    input  logic [ADDR_W-1:0] i_bus_addr,
    input  logic              i_bus_we,
    input  logic [COEF_W-1:0] i_bus_wdata,
    input  logic [ADDR_W-1:0] i_rd_addr_a,
    input  logic [ADDR_W-1:0] i_rd_addr_b,
    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_wr_addr_a,
    input  logic [ADDR_W-1:0] i_wr_addr_b,
    input  logic [COEF_W-1:0] i_wr_data_a,
    input  logic [COEF_W-1:0] i_wr_data_b,
    output logic [COEF_W-1:0] o_bus_rdata,
    output logic [COEF_W-1:0] o_rd_data_a,
    output logic [COEF_W-1:0] o_rd_data_b
);

    logic [COEF_W-1:0] mem [NTT_N];

    // the coefficient slots come up as zero after reset
    always_ff @(posedge ntt_clk_i or posedge ntt_rst_ni) begin
        if (ntt_rst_ni) begin
            for (int i = 0; i < NTT_N; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (i_bus_we) begin
                mem[i_bus_addr] <= i_bus_wdata;
            end
            // one butterfly result puts both of its words back in place
            if (i_wr_en) begin
                mem[i_wr_addr_a] <= i_wr_data_a;
                mem[i_wr_addr_b] <= i_wr_data_b;
            end
        end
    end

    // registered reads, a read in the same cycle as a write returns the old word
    always_ff @(posedge ntt_clk_i) begin
        o_bus_rdata <= mem[i_bus_addr];
        o_rd_data_a <= mem[i_rd_addr_a];
        o_rd_data_b <= mem[i_rd_addr_b];
    end

    // the bus front end only writes while the engine is idle
    a_no_dual_write : assert property (@(posedge ntt_clk_i) disable iff (ntt_rst_ni)
        !(i_bus_we && i_wr_en));

endmodule

//--- design/ntt_sequencer.sv
`timescale 1ns/1ps

module ntt_sequencer import ntt_pkg::*; (
    input  logic              ntt_clk_i,
    input  logic              ntt_rst_ni,
    input  logic              i_start,
    output logic              o_busy,
    output logic              o_done_pulse,
    output logic [ADDR_W-1:0] o_rd_addr_a,
    output logic [ADDR_W-1:0] o_rd_addr_b,
    output logic              o_valid,
    output logic [COEF_W-1:0] o_twiddle,
    output logic [ADDR_W-1:0] o_addr_a,
    output logic [ADDR_W-1:0] o_addr_b
);

    ntt_state_e        state_q;
    logic [1:0]        stage_q;
    logic [1:0]        bfly_q;
    logic [1:0]        drain_q;
    logic [ADDR_W-1:0] span;
    logic [1:0]        group;
    logic              issue;

    // stage s pairs indices that are 4 >> s apart
    assign span = ADDR_W'(NTT_N / 2) >> stage_q;

    // butterfly group within the stage, one group in stage 0 and four in stage 2
    assign group = bfly_q >> (2'(NTT_STAGES - 1) - stage_q);

    // the group picks the block base and the low butterfly bits pick the slot in it
    assign o_rd_addr_a = (ADDR_W'(group) << (ADDR_W - int'(stage_q)))
                       | (ADDR_W'(bfly_q) & (span - 1'b1));
    assign o_rd_addr_b = o_rd_addr_a | span;

    // one read pair per cycle, only in the issue state
    assign issue = (state_q == NTT_ISSUE);

    assign o_busy       = (state_q != NTT_IDLE);
    assign o_done_pulse = (state_q == NTT_DONE);

    always_ff @(posedge ntt_clk_i or posedge ntt_rst_ni) begin
        if (ntt_rst_ni) begin
            state_q <= NTT_IDLE;
            stage_q <= '0;
            bfly_q  <= '0;
            drain_q <= '0;
        end else begin
            case (state_q)
                NTT_IDLE: begin
                    if (i_start) begin
                        state_q <= NTT_ISSUE;
                        stage_q <= '0;
                        bfly_q  <= '0;
                    end
                end
                NTT_ISSUE: begin
                    // the counter wraps back to zero for the next stage
                    bfly_q <= bfly_q + 2'd1;
                    if (bfly_q == 2'(BFLY_PER_STAGE - 1)) begin
                        state_q <= NTT_DRAIN;
                        drain_q <= '0;
                    end
                end
                NTT_DRAIN: begin
                    // three drain cycles cover the ram read and the two butterfly stages
                    // in the last stage the done cycle stands in for the third one
                    drain_q <= drain_q + 2'd1;
                    if (stage_q == 2'(NTT_STAGES - 1) && drain_q == 2'd1) begin
                        state_q <= NTT_DONE;
                    end else if (drain_q == 2'd2) begin
                        state_q <= NTT_ISSUE;
                        stage_q <= stage_q + 2'd1;
                    end
                end
                default: begin
                    state_q <= NTT_IDLE;
                end
            endcase
        end
    end

    // valid is delayed by one clock to line up with the ram read data
    always_ff @(posedge ntt_clk_i or posedge ntt_rst_ni) begin
        if (ntt_rst_ni) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= issue;
        end
    end

    // write-back addresses and the twiddle travel with the data
    // the twiddle index is the group number in bit-reversed order
    always_ff @(posedge ntt_clk_i) begin
        o_addr_a  <= o_rd_addr_a;
        o_addr_b  <= o_rd_addr_b;
        o_twiddle <= TWIDDLE_TABLE[{group[0], group[1]}];
    end

    // a stage starts reading only after three cycles without a read,
    // so every result of the stage before is back in the memory
    a_no_read_in_drain : assert property (@(posedge ntt_clk_i) disable iff (ntt_rst_ni)
        $rose(issue) |-> !$past(issue, 2) && !$past(issue, 3));

endmodule

//--- design/ntt_butterfly.sv
`timescale 1ns/1ps

module ntt_butterfly import ntt_pkg::*; (
    input  logic              ntt_clk_i,
    input  logic              ntt_rst_ni,
    input  logic              i_valid,
    input  logic [COEF_W-1:0] i_a,
    input  logic [COEF_W-1:0] i_b,
    input  logic [COEF_W-1:0] i_twiddle,
    input  logic [ADDR_W-1:0] i_addr_a,
    input  logic [ADDR_W-1:0] i_addr_b,
    output logic              o_valid,
    output logic [COEF_W-1:0] o_a,
    output logic [COEF_W-1:0] o_b,
    output logic [ADDR_W-1:0] o_addr_a,
    output logic [ADDR_W-1:0] o_addr_b
);

    logic [2*COEF_W-1:0] prod;
    logic [3*COEF_W:0]   prod_m;
    logic [COEF_W:0]     quot;
    logic [2*COEF_W-1:0] rem;
    logic [COEF_W-1:0]   t_red;
    logic                v1_q;
    logic [COEF_W-1:0]   a1_q;
    logic [COEF_W-1:0]   t1_q;
    logic [ADDR_W-1:0]   addr_a1_q;
    logic [ADDR_W-1:0]   addr_b1_q;
    logic [COEF_W:0]     sum;
    logic [COEF_W:0]     diff;

    // stage 1 forms t = w * b and brings it below q with a barrett estimate
    assign prod   = i_twiddle * i_b;
    assign prod_m = prod * BARRETT_M;
    assign quot   = prod_m[BARRETT_SHIFT +: COEF_W+1];

    // the quotient estimate is low by at most one, so one correction is enough
    assign rem   = prod - (2*COEF_W)'(quot) * (2*COEF_W)'(NTT_Q);
    assign t_red = (rem >= (2*COEF_W)'(NTT_Q)) ? COEF_W'(rem - (2*COEF_W)'(NTT_Q))
                                                : COEF_W'(rem);

    // stage 2 forms a + t and a - t, the difference is taken as a + (q - t)
    assign sum  = {1'b0, a1_q} + {1'b0, t1_q};
    assign diff = {1'b0, a1_q} + {1'b0, NTT_Q - t1_q};

    always_ff @(posedge ntt_clk_i or posedge ntt_rst_ni) begin
        if (ntt_rst_ni) begin
            v1_q    <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            v1_q    <= i_valid;
            o_valid <= v1_q;
        end
    end

    always_ff @(posedge ntt_clk_i) begin
        a1_q      <= i_a;
        t1_q      <= t_red;
        addr_a1_q <= i_addr_a;
        addr_b1_q <= i_addr_b;
        // both sums lie below 2q, so one subtract brings them into [0, q)
        o_a <= (sum >= {1'b0, NTT_Q}) ? COEF_W'(sum - {1'b0, NTT_Q}) : sum[COEF_W-1:0];
        o_b <= (diff >= {1'b0, NTT_Q}) ? COEF_W'(diff - {1'b0, NTT_Q}) : diff[COEF_W-1:0];
        o_addr_a <= addr_a1_q;
        o_addr_b <= addr_b1_q;
    end

    // the memory and the twiddle table only ever hold reduced values
    a_inputs_reduced : assert property (@(posedge ntt_clk_i) disable iff (ntt_rst_ni)
        i_valid |-> (i_a < NTT_Q) && (i_b < NTT_Q) && (i_twiddle < NTT_Q));

endmodule

//--- design/ntt_top.sv
`timescale 1ns/1ps

module ntt_top import ntt_pkg::*; (
    input  logic              ntt_clk_i,
    input  logic              ntt_rst_ni,
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  logic [3:0]        i_wb_adr,
    input  logic [BUS_DW-1:0] i_wb_dat,
    output logic [BUS_DW-1:0] o_wb_dat,
    output logic              o_wb_ack,
    output logic              o_wb_err,
    output logic              o_ntt_intr
);

    // bus side of the coefficient memory
    logic [ADDR_W-1:0] bus_addr;
    logic              bus_we;
    logic [COEF_W-1:0] bus_wdata;
    logic [COEF_W-1:0] bus_rdata;

    // engine control
    logic start;
    logic busy;
    logic done_pulse;

    // engine read port and butterfly input
    logic [ADDR_W-1:0] rd_addr_a;
    logic [ADDR_W-1:0] rd_addr_b;
    logic [COEF_W-1:0] rd_data_a;
    logic [COEF_W-1:0] rd_data_b;
    logic              bf_in_valid;
    logic [COEF_W-1:0] bf_twiddle;
    logic [ADDR_W-1:0] bf_in_addr_a;
    logic [ADDR_W-1:0] bf_in_addr_b;

    // butterfly result back into the memory
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr_a;
    logic [ADDR_W-1:0] wr_addr_b;
    logic [COEF_W-1:0] wr_data_a;
    logic [COEF_W-1:0] wr_data_b;

    ntt_wb_slave u_wb_slave (
        .ntt_clk_i    (ntt_clk_i),
        .ntt_rst_ni   (ntt_rst_ni),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .i_bus_rdata  (bus_rdata),
        .i_busy       (busy),
        .i_done_pulse (done_pulse),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_wb_err     (o_wb_err),
        .o_ntt_intr   (o_ntt_intr),
        .o_bus_addr   (bus_addr),
        .o_bus_we     (bus_we),
        .o_bus_wdata  (bus_wdata),
        .o_start      (start)
    );

    ntt_coef_ram u_coef_ram (
        .ntt_clk_i   (ntt_clk_i),
        .ntt_rst_ni  (ntt_rst_ni),
        .i_bus_addr  (bus_addr),
        .i_bus_we    (bus_we),
        .i_bus_wdata (bus_wdata),
        .i_rd_addr_a (rd_addr_a),
        .i_rd_addr_b (rd_addr_b),
        .i_wr_en     (wr_en),
        .i_wr_addr_a (wr_addr_a),
        .i_wr_addr_b (wr_addr_b),
        .i_wr_data_a (wr_data_a),
        .i_wr_data_b (wr_data_b),
        .o_bus_rdata (bus_rdata),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    ntt_sequencer u_sequencer (
        .ntt_clk_i    (ntt_clk_i),
        .ntt_rst_ni   (ntt_rst_ni),
        .i_start      (start),
        .o_busy       (busy),
        .o_done_pulse (done_pulse),
        .o_rd_addr_a  (rd_addr_a),
        .o_rd_addr_b  (rd_addr_b),
        .o_valid      (bf_in_valid),
        .o_twiddle    (bf_twiddle),
        .o_addr_a     (bf_in_addr_a),
        .o_addr_b     (bf_in_addr_b)
    );

    ntt_butterfly u_butterfly (
        .ntt_clk_i  (ntt_clk_i),
        .ntt_rst_ni (ntt_rst_ni),
        .i_valid    (bf_in_valid),
        .i_a        (rd_data_a),
        .i_b        (rd_data_b),
        .i_twiddle  (bf_twiddle),
        .i_addr_a   (bf_in_addr_a),
        .i_addr_b   (bf_in_addr_b),
        .o_valid    (wr_en),
        .o_a        (wr_data_a),
        .o_b        (wr_data_b),
        .o_addr_a   (wr_addr_a),
        .o_addr_b   (wr_addr_b)
    );

endmodule

//--- verif/ntt_tb.sv
`timescale 1ns/1ps

module ntt_tb import ntt_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 200;
    localparam int BUS_TIMEOUT = 16;
    localparam int POLL_LIMIT  = 40;

    logic              clk;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [3:0]        wb_adr;
    logic [BUS_DW-1:0] wb_dat_w;
    logic [BUS_DW-1:0] wb_dat_r;
    logic              wb_ack;
    logic              wb_err;
    logic              intr;

    // two tests, each with eight inputs followed by eight expected words
    logic [COEF_W-1:0] vec_mem [0:4*NTT_N-1];
    logic [31:0]       lfsr_state;
    int                errors;
    int                err_mark;
    int                test_num;
    int                tests_passed;
    logic [31:0]       rdat;
    logic              ack;
    logic              err;

    ntt_top dut0 (
        .ntt_clk_i  (clk),
        .ntt_rst_ni (rst),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_adr   (wb_adr),
        .i_wb_dat   (wb_dat_w),
        .o_wb_dat   (wb_dat_r),
        .o_wb_ack   (wb_ack),
        .o_wb_err   (wb_err),
        .o_ntt_intr (intr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // zero to three idle cycles between transactions, two lfsr bits
    task idle_gap();
        int gap;
        gap = 0;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            gap = (gap << 1) | int'(lfsr_state[0]);
        end
        repeat (gap) @(negedge clk);
    endtask

    task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one classic cycle, held until ack or err shows up at a falling edge
    task bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                    output logic [31:0] data, output logic got_ack, output logic got_err);
        int n;
        idle_gap();
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(wb_ack || wb_err) && n < BUS_TIMEOUT);
        got_ack = wb_ack;
        got_err = wb_err;
        data    = wb_dat_r;
        if (!(got_ack || got_err)) begin
            $display("bus access to address %0d got neither ack nor err in %0d cycles",
                     adr, BUS_TIMEOUT);
            errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] ignored;
        logic        a;
        logic        e;
        bus_access(1'b1, adr, wdat, ignored, a, e);
        check_value($sformatf("ack on write to address %0d", adr), 32'(a), 32'd1);
    endtask

    task wb_read(input logic [3:0] adr, output logic [31:0] data);
        logic a;
        logic e;
        bus_access(1'b0, adr, 32'd0, data, a, e);
        check_value($sformatf("ack on read of address %0d", adr), 32'(a), 32'd1);
    endtask

    task load_inputs(input int set);
        for (int i = 0; i < NTT_N; i++) begin
            wb_write(4'(i), 32'(vec_mem[set*2*NTT_N + i]));
        end
    endtask

    task check_outputs(input int set);
        logic [31:0] d;
        for (int i = 0; i < NTT_N; i++) begin
            wb_read(4'(i), d);
            check_value($sformatf("set %0d slot %0d result", set + 1, i), d,
                        32'(vec_mem[set*2*NTT_N + NTT_N + i]));
        end
    endtask

    task start_transform();
        wb_write(4'(REG_CTRL), 32'd1 << CTRL_START);
    endtask

    // poll the status word until the done bit shows up
    task wait_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[STAT_DONE] && polls < POLL_LIMIT) begin
            wb_read(4'(REG_CTRL), st);
            polls++;
        end
        if (!st[STAT_DONE]) begin
            $display("transform did not finish within %0d status polls", POLL_LIMIT);
            errors++;
        end
    endtask

    task begin_test();
        err_mark = errors;
    endtask

    task end_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %0d (%s): passed", test_num, name);
        end else begin
            $display("test %0d (%s): failed with %0d errors", test_num, name, errors - err_mark);
        end
    endtask

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired, tests did not finish in %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        lfsr_state   = 32'h301f3563;
        errors       = 0;
        err_mark     = 0;
        test_num     = 0;
        tests_passed = 0;
        $readmemh("verif/ntt_vectors.mem", vec_mem);
        if ($isunknown(vec_mem[4*NTT_N-1])) begin
            $display("vector file verif/ntt_vectors.mem could not be read");
            errors++;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test();
        wb_read(4'(REG_CTRL), rdat);
        check_value("status after reset", rdat, 32'd0);
        check_value("interrupt after reset", 32'(intr), 32'd0);
        for (int i = 0; i < NTT_N; i++) begin
            wb_read(4'(i), rdat);
            check_value($sformatf("slot %0d after reset", i), rdat, 32'd0);
        end
        load_inputs(0);
        for (int i = 0; i < NTT_N; i++) begin
            wb_read(4'(i), rdat);
            check_value($sformatf("slot %0d read-back", i), rdat, 32'(vec_mem[i]));
        end
        end_test("reset state and idle read-back");

        begin_test();
        start_transform();
        wait_done();
        check_value("interrupt after first transform", 32'(intr), 32'd1);
        check_outputs(0);
        end_test("transform of set 1");

        // done stays set until the next start clears it
        begin_test();
        load_inputs(1);
        start_transform();
        wb_read(4'(REG_CTRL), rdat);
        check_value("status right after second start", rdat, 32'd1 << STAT_BUSY);
        check_value("interrupt right after second start", 32'(intr), 32'd0);
        wait_done();
        check_value("interrupt after second transform", 32'(intr), 32'd1);
        check_outputs(1);
        end_test("transform of set 2");

        begin_test();
        start_transform();
        bus_access(1'b0, 4'd3, 32'd0, rdat, ack, err);
        check_value("err on busy coefficient read", 32'(err), 32'd1);
        check_value("ack on busy coefficient read", 32'(ack), 32'd0);
        bus_access(1'b1, 4'd5, 32'h123, rdat, ack, err);
        check_value("err on busy coefficient write", 32'(err), 32'd1);
        check_value("ack on busy coefficient write", 32'(ack), 32'd0);
        wb_read(4'(REG_CTRL), rdat);
        check_value("busy bit during transform", 32'(rdat[STAT_BUSY]), 32'd1);
        wait_done();
        end_test("coefficient access while busy");

        begin_test();
        bus_access(1'b0, 4'd9, 32'd0, rdat, ack, err);
        check_value("err on idle read of address 9", 32'(err), 32'd1);
        check_value("ack on idle read of address 9", 32'(ack), 32'd0);
        bus_access(1'b1, 4'd15, 32'd7, rdat, ack, err);
        check_value("err on idle write of address 15", 32'(err), 32'd1);
        check_value("ack on idle write of address 15", 32'(ack), 32'd0);
        start_transform();
        bus_access(1'b0, 4'd12, 32'd0, rdat, ack, err);
        check_value("err on busy read of address 12", 32'(err), 32'd1);
        check_value("ack on busy read of address 12", 32'(ack), 32'd0);
        wait_done();
        end_test("address above the register map");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 test_num, tests_passed, test_num - tests_passed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/ntt_vectors.mem
// per test: eight input words for slots 0 to 7, then eight expected words for slots 0 to 7
// expected slot p holds X[bitrev(p)] = sum a_j * w^(j*bitrev(p)) mod 3329, w = 2580, hex
001
002
003
004
005
006
007
008
024
cfd
bfb
0fe
b4e
ca8
051
1ab
d00
064
7d0
007
001
ce4
032
680
1cf
134
4fe
500
8ac
ba4
63f
c6c

//--- tb.f
design/ntt_pkg.sv
design/ntt_wb_slave.sv
design/ntt_coef_ram.sv
design/ntt_sequencer.sv
design/ntt_butterfly.sv
design/ntt_top.sv
verif/ntt_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the NTT testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module ntt_tb -f tb.f -o ntt_sim &&
./obj_dir/ntt_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
